// File: hdl/mouse_position.sv
// mouse position tracker
// accumulates clamped x deltas into a signed position on each report toggle
`timescale 1ns/1ps

module mouse_position (
	input logic clk,
	input logic reset,
	input paddle_pkg::mouse_report_t mouse,
	output logic [paddle_pkg::POS_W-1:0] mouse_pos
);
	import paddle_pkg::*;

	logic strobe_q;
	logic signed [POS_W-1:0] acc;
	logic signed [POS_W:0] delta;
	logic signed [POS_W:0] step;
	logic signed [POS_W:0] sum;

	always_comb begin
		// 9 bit signed delta from sign and magnitude byte
		delta = {mouse.dx_sign, mouse.dx};
		if (delta > MOUSE_STEP_MAX)
			step = (POS_W+1)'(MOUSE_STEP_MAX);
		else if (delta < -MOUSE_STEP_MAX)
			step = (POS_W+1)'(-MOUSE_STEP_MAX);
		else
			step = delta;
		// cannot overflow 9 bits with a byte accumulator
		sum = acc + step;
	end

	always_ff @(posedge clk) begin
		// strobe copy tracks the report even in reset
		// so releasing reset never looks like a toggle
		strobe_q <= mouse.strobe;
		if (reset) begin
			acc <= '0;
		end else if (mouse.strobe != strobe_q) begin
			if (sum > MOUSE_POS_MAX)
				acc <= POS_W'(MOUSE_POS_MAX);
			else if (sum < MOUSE_POS_MIN)
				acc <= POS_W'(MOUSE_POS_MIN);
			else
				acc <= sum[POS_W-1:0];
		end
	end

	// offset binary for the mux
	assign mouse_pos = to_offset(acc);

	// position moves only on a toggle and by no more than one clamped step
	assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && acc != $past(acc) |->
			$past(mouse.strobe != strobe_q) &&
			acc - $past(acc) <= MOUSE_STEP_MAX &&
			acc - $past(acc) >= -MOUSE_STEP_MAX);

endmodule

// File: hdl/paddle_assigner.sv
// slot assigner
// fills the lowest open slot with the highest priority unclaimed source
// one claim per cycle, each source claims at most one slot
`timescale 1ns/1ps

module paddle_assigner (
	input logic clk,
	input logic reset,
	input logic [paddle_pkg::NUM_SLOTS-1:0] mask,
	input paddle_pkg::swing_events_t events,
	input logic mouse_button,
	output logic [paddle_pkg::NUM_SLOTS-1:0] assigned,
	output logic [paddle_pkg::NUM_SLOTS-1:0] filled,
	output paddle_pkg::slot_source_t [paddle_pkg::NUM_SLOTS-1:0] slot_src
);
	import paddle_pkg::*;

	// claimed flags per source
	logic [NUM_SOURCES-1:0] spinner_claimed;
	// one flag covers both axes of a stick
	logic [NUM_SOURCES-1:0] stick_claimed;
	logic mouse_claimed;

	logic [NUM_SLOTS-1:0] open;
	logic [NUM_SLOTS-1:0] target_oh;
	logic pick_valid;
	slot_source_t pick;
	logic take;

	// lowest enabled slot not yet filled
	assign open = mask & ~filled;
	assign target_oh = open & (~open + 1'b1);

	always_comb begin
		pick_valid = 1'b0;
		pick = '{kind: KIND_SPINNER, index: 2'd0, x_axis: 1'b0};
		// lowest priority first, later hits override
		// stick x axes
		for (int i = 0; i < NUM_SOURCES; i++) begin
			if (events.stick_x[i] && !stick_claimed[i]) begin
				pick_valid = 1'b1;
				pick = '{kind: KIND_STICK, index: 2'(i), x_axis: 1'b1};
			end
		end
		// stick y axes
		for (int i = 0; i < NUM_SOURCES; i++) begin
			if (events.stick_y[i] && !stick_claimed[i]) begin
				pick_valid = 1'b1;
				pick = '{kind: KIND_STICK, index: 2'(i), x_axis: 1'b0};
			end
		end
		// spinners
		for (int i = 0; i < NUM_SOURCES; i++) begin
			if (events.spinner[i] && !spinner_claimed[i]) begin
				pick_valid = 1'b1;
				pick = '{kind: KIND_SPINNER, index: 2'(i), x_axis: 1'b0};
			end
		end
		// mouse press beats everything
		if (mouse_button && !mouse_claimed) begin
			pick_valid = 1'b1;
			pick = '{kind: KIND_MOUSE, index: 2'd0, x_axis: 1'b0};
		end
	end

	// nothing happens once every enabled slot is taken
	assign take = pick_valid && |open;

	always_ff @(posedge clk) begin
		if (reset) begin
			assigned <= '0;
			filled <= '0;
			slot_src <= '0;
			spinner_claimed <= '0;
			stick_claimed <= '0;
			mouse_claimed <= 1'b0;
		end else begin
			// assigned is a single cycle pulse
			assigned <= '0;
			if (take) begin
				assigned <= target_oh;
				filled <= filled | target_oh;
				for (int s = 0; s < NUM_SLOTS; s++) begin
					if (target_oh[s])
						slot_src[s] <= pick;
				end
				case (pick.kind)
					KIND_SPINNER: spinner_claimed[pick.index] <= 1'b1;
					KIND_STICK: stick_claimed[pick.index] <= 1'b1;
					KIND_MOUSE: mouse_claimed <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// at most one slot per cycle
	assert property (@(posedge clk) disable iff (reset) $onehot0(assigned));

	// a pulse only lands on a slot that was enabled and open the cycle before
	assert property (@(posedge clk) disable iff (reset)
		(assigned & ~$past(mask & ~filled)) == '0);

endmodule

// File: hdl/paddle_chooser.sv
// paddle chooser top level
// swing detector and mouse tracker feed the slot assigner
// the output mux presents each filled slot as a paddle
`timescale 1ns/1ps

module paddle_chooser (
	input logic clk,
	input logic reset,
	input logic [paddle_pkg::NUM_SLOTS-1:0] mask,
	input paddle_pkg::stick_t [paddle_pkg::NUM_SOURCES-1:0] stick,
	input logic [paddle_pkg::NUM_SOURCES-1:0][paddle_pkg::POS_W-1:0] spinner,
	input paddle_pkg::mouse_report_t mouse,
	input logic [paddle_pkg::NUM_SOURCES-1:0] buttons_in,
	output logic [paddle_pkg::NUM_SLOTS-1:0] assigned,
	output logic [paddle_pkg::NUM_SLOTS-1:0][paddle_pkg::POS_W-1:0] pd_out,
	output paddle_pkg::paddle_kind_e [paddle_pkg::NUM_SLOTS-1:0] paddle_kind,
	output logic [paddle_pkg::NUM_SLOTS-1:0] paddle_but
);
	import paddle_pkg::*;

	swing_events_t events;
	logic [POS_W-1:0] mouse_pos;
	logic [NUM_SLOTS-1:0] filled;
	slot_source_t [NUM_SLOTS-1:0] slot_src;

	// change to extreme on any stick axis or spinner
	swing_detect swing_detect_inst (
		.clk(clk),
		.stick(stick),
		.spinner(spinner),
		.events(events)
	);

	mouse_position mouse_position_inst (
		.clk(clk),
		.reset(reset),
		.mouse(mouse),
		.mouse_pos(mouse_pos)
	);

	paddle_assigner paddle_assigner_inst (
		.clk(clk),
		.reset(reset),
		.mask(mask),
		.events(events),
		.mouse_button(mouse.button),
		.assigned(assigned),
		.filled(filled),
		.slot_src(slot_src)
	);

	paddle_mux paddle_mux_inst (
		.filled(filled),
		.slot_src(slot_src),
		.stick(stick),
		.spinner(spinner),
		.buttons_in(buttons_in),
		.mouse_pos(mouse_pos),
		.mouse_button(mouse.button),
		.pd_out(pd_out),
		.paddle_but(paddle_but)
	);

	// kind of each slot straight from the recorded source
	for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_kind
		assign paddle_kind[s] = slot_src[s].kind;
	end

endmodule

// File: hdl/paddle_mux.sv
// paddle output mux
// routes the recorded source of each filled slot to its position byte and button
`timescale 1ns/1ps

module paddle_mux (
	input logic [paddle_pkg::NUM_SLOTS-1:0] filled,
	input paddle_pkg::slot_source_t [paddle_pkg::NUM_SLOTS-1:0] slot_src,
	input paddle_pkg::stick_t [paddle_pkg::NUM_SOURCES-1:0] stick,
	input logic [paddle_pkg::NUM_SOURCES-1:0][paddle_pkg::POS_W-1:0] spinner,
	input logic [paddle_pkg::NUM_SOURCES-1:0] buttons_in,
	input logic [paddle_pkg::POS_W-1:0] mouse_pos,
	input logic mouse_button,
	output logic [paddle_pkg::NUM_SLOTS-1:0][paddle_pkg::POS_W-1:0] pd_out,
	output logic [paddle_pkg::NUM_SLOTS-1:0] paddle_but
);
	import paddle_pkg::*;

	logic stick0_used;

	// stick 0 button doubles as a mouse button until stick 0 owns a slot
	always_comb begin
		stick0_used = 1'b0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (filled[s] && slot_src[s].kind == KIND_STICK && slot_src[s].index == 2'd0)
				stick0_used = 1'b1;
		end
	end

	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			// open slots read zero
			pd_out[s] = '0;
			paddle_but[s] = 1'b0;
			if (filled[s]) begin
				case (slot_src[s].kind)
					KIND_SPINNER: begin
						pd_out[s] = ~spinner[slot_src[s].index];
						paddle_but[s] = buttons_in[slot_src[s].index];
					end
					KIND_STICK: begin
						// recorded axis in offset binary, then inverted
						if (slot_src[s].x_axis)
							pd_out[s] = ~to_offset(stick[slot_src[s].index].x);
						else
							pd_out[s] = ~to_offset(stick[slot_src[s].index].y);
						paddle_but[s] = buttons_in[slot_src[s].index];
					end
					KIND_MOUSE: begin
						pd_out[s] = ~mouse_pos;
						paddle_but[s] = mouse_button | (buttons_in[0] & ~stick0_used);
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: hdl/paddle_pkg.sv
// paddle chooser shared definitions
// source counts, byte widths, mouse clamp limits and the slot bookkeeping types
package paddle_pkg;

	// four paddle slots fed from four of each source type
	localparam int NUM_SLOTS = 4;
	localparam int NUM_SOURCES = 4;
	localparam int POS_W = 8;

	// largest mouse delta taken per report
	localparam int MOUSE_STEP_MAX = 15;
	// accumulator range matches a signed position byte
	localparam int MOUSE_POS_MIN = -128;
	localparam int MOUSE_POS_MAX = 127;

	// analog stick word with y in the upper byte
	typedef struct packed {
		logic signed [POS_W-1:0] y;
		logic signed [POS_W-1:0] x;
	} stick_t;

	// ps/2 report, bit 24 toggles once per new report
	typedef struct packed {
		logic strobe;
		logic [7:0] rsvd_hi;
		logic [POS_W-1:0] dx;
		logic [2:0] rsvd_mid;
		logic dx_sign;
		logic [2:0] rsvd_lo;
		logic button;
	} mouse_report_t;

	// one select bit per detector channel
	typedef struct packed {
		logic [NUM_SOURCES-1:0] stick_x;
		logic [NUM_SOURCES-1:0] stick_y;
		logic [NUM_SOURCES-1:0] spinner;
	} swing_events_t;

	typedef enum logic [1:0] {
		KIND_SPINNER = 2'd0,
		KIND_STICK = 2'd1,
		KIND_MOUSE = 2'd2
	} paddle_kind_e;

	// recorded source of a filled slot
	typedef struct packed {
		paddle_kind_e kind;
		logic [1:0] index;
		logic x_axis;
	} slot_source_t;

	// two's complement byte to offset binary
	function automatic logic [POS_W-1:0] to_offset(input logic [POS_W-1:0] value);
		return {~value[POS_W-1], value[POS_W-2:0]};
	endfunction

endpackage

// File: hdl/swing_detect.sv
// swing detector for sticks and spinners
// flags a channel for one cycle when its value changes and ends up in the
// top or bottom quarter of the range
`timescale 1ns/1ps

module swing_detect (
	input logic clk,
	input paddle_pkg::stick_t [paddle_pkg::NUM_SOURCES-1:0] stick,
	input logic [paddle_pkg::NUM_SOURCES-1:0][paddle_pkg::POS_W-1:0] spinner,
	output paddle_pkg::swing_events_t events
);
	import paddle_pkg::*;

	// channel layout follows swing_events_t packing
	// stick x on top, then stick y, spinners at the bottom
	logic [$bits(swing_events_t)-1:0][POS_W-1:0] chan;
	logic [$bits(swing_events_t)-1:0][POS_W-1:0] last;
	logic [$bits(swing_events_t)-1:0] sel;

	always_comb begin
		for (int i = 0; i < NUM_SOURCES; i++) begin
			chan[2*NUM_SOURCES+i] = to_offset(stick[i].x);
			chan[NUM_SOURCES+i] = to_offset(stick[i].y);
			// spinners are already unsigned
			chan[i] = spinner[i];
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < $bits(swing_events_t); c++) begin
			last[c] <= chan[c];
			// extreme means top two bits equal
			sel[c] <= (chan[c] != last[c]) &&
				(&chan[c][POS_W-1:POS_W-2] || ~|chan[c][POS_W-1:POS_W-2]);
		end
	end

	assign events = swing_events_t'(sel);

	// back to back selects on one input need a fresh change of that same input
	for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_chk
		assert property (@(posedge clk)
			events.spinner[i] && $past(events.spinner[i]) |->
				$past(spinner[i], 1) != $past(spinner[i], 2));
		assert property (@(posedge clk)
			events.stick_y[i] && $past(events.stick_y[i]) |->
				$past(stick[i].y, 1) != $past(stick[i].y, 2));
		assert property (@(posedge clk)
			events.stick_x[i] && $past(events.stick_x[i]) |->
				$past(stick[i].x, 1) != $past(stick[i].x, 2));
	end

endmodule

// File: paddle_chooser.f
hdl/paddle_pkg.sv
hdl/swing_detect.sv
hdl/mouse_position.sv
hdl/paddle_assigner.sv
hdl/paddle_mux.sv
hdl/paddle_chooser.sv
verification/tb_clock_gen.sv
verification/paddle_chooser_tb.sv

// File: verification/paddle_chooser_tb.sv
// paddle chooser testbench
// drives swings, mask changes and mouse reports and checks every slot against a model
`timescale 1ns/1ps

module paddle_chooser_tb;
	import paddle_pkg::*;

	// expected view of one slot
	typedef struct packed {
		logic [POS_W-1:0] pd;
		logic but;
		paddle_kind_e kind;
	} slot_view_t;

	logic clk;
	logic reset;
	logic [NUM_SLOTS-1:0] mask;
	stick_t [NUM_SOURCES-1:0] stick;
	logic [NUM_SOURCES-1:0][POS_W-1:0] spinner;
	mouse_report_t mouse;
	logic [NUM_SOURCES-1:0] buttons_in;
	logic [NUM_SLOTS-1:0] assigned;
	logic [NUM_SLOTS-1:0][POS_W-1:0] pd_out;
	paddle_kind_e [NUM_SLOTS-1:0] paddle_kind;
	logic [NUM_SLOTS-1:0] paddle_but;

	// model of the slot state and the mouse accumulator
	logic [NUM_SLOTS-1:0] exp_filled;
	slot_source_t exp_src [NUM_SLOTS];
	int exp_acc;
	bit check_en;
	int errors;
	int tests;
	int test_err_start;
	integer seed;

	tb_clock_gen tb_clock_gen_inst (
		.clk(clk),
		.reset(reset)
	);

	paddle_chooser paddle_chooser_inst (
		.clk(clk),
		.reset(reset),
		.mask(mask),
		.stick(stick),
		.spinner(spinner),
		.mouse(mouse),
		.buttons_in(buttons_in),
		.assigned(assigned),
		.pd_out(pd_out),
		.paddle_kind(paddle_kind),
		.paddle_but(paddle_but)
	);

	function automatic slot_source_t source_of(paddle_kind_e kind, int index, bit x_axis);
		slot_source_t src;
		src.kind = kind;
		src.index = 2'(index);
		src.x_axis = x_axis;
		return src;
	endfunction

	function automatic int clamp(int value, int lo, int hi);
		return (value < lo) ? lo : ((value > hi) ? hi : value);
	endfunction

	// reference for one slot from the recorded source and the live inputs
	// inverting an offset binary byte of signed value v gives 127 - v
	function automatic slot_view_t expected_slot(int s);
		slot_view_t v;
		slot_source_t src;
		bit stick0_taken;
		int axis;
		src = exp_src[s];
		v.kind = src.kind;
		v.pd = '0;
		v.but = 1'b0;
		stick0_taken = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (exp_filled[i] && exp_src[i].kind == KIND_STICK && exp_src[i].index == 0)
				stick0_taken = 1'b1;
		end
		if (exp_filled[s]) begin
			case (src.kind)
				KIND_SPINNER: begin
					v.pd = 8'(255 - int'(spinner[src.index]));
					v.but = buttons_in[src.index];
				end
				KIND_STICK: begin
					axis = src.x_axis ? $signed(stick[src.index].x) : $signed(stick[src.index].y);
					v.pd = 8'(127 - axis);
					v.but = buttons_in[src.index];
				end
				default: begin
					v.pd = 8'(127 - exp_acc);
					v.but = mouse.button | (buttons_in[0] & ~stick0_taken);
				end
			endcase
		end
		return v;
	endfunction

	task automatic check_assigned(input logic [NUM_SLOTS-1:0] got, input logic [NUM_SLOTS-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH assigned: got %h, expected %h", got, exp);
		end
	endtask

	task automatic check_pd_out(input int slot, input logic [POS_W-1:0] got,
			input logic [POS_W-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH pd_out[%0d]: got %h, expected %h", slot, got, exp);
		end
	endtask

	task automatic check_kind(input int slot, input paddle_kind_e got, input paddle_kind_e exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH paddle_kind[%0d]: got %h, expected %h", slot, got, exp);
		end
	endtask

	task automatic check_button(input int slot, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH paddle_but[%0d]: got %h, expected %h", slot, got, exp);
		end
	endtask

	// slot outputs compared away from the driving edge
	always @(negedge clk) begin : compare_slots
		slot_view_t v;
		if (check_en) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				v = expected_slot(s);
				check_pd_out(s, pd_out[s], v.pd);
				check_kind(s, paddle_kind[s], v.kind);
				check_button(s, paddle_but[s], v.but);
			end
		end
	end

	// waits for the claim pulse and records the source in the lowest open slot
	task automatic expect_claim(input slot_source_t src);
		int target;
		int waited;
		bit seen;
		logic [NUM_SLOTS-1:0] exp_oh;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < 10) begin
			@(negedge clk);
			waited++;
			if (assigned !== '0)
				seen = 1'b1;
		end
		target = -1;
		for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
			if (mask[s] && !exp_filled[s])
				target = s;
		end
		if (!seen) begin
			errors++;
			$display("no assigned pulse within %0d cycles", waited);
		end else if (target < 0) begin
			errors++;
			$display("assigned pulse seen while no enabled slot was open");
		end else begin
			exp_oh = '0;
			exp_oh[target] = 1'b1;
			check_assigned(assigned, exp_oh);
			exp_filled[target] = 1'b1;
			exp_src[target] = src;
		end
		// pulse lasts one cycle
		@(negedge clk);
		check_assigned(assigned, '0);
		check_en = 1'b1;
	endtask

	task automatic expect_no_claim(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			check_assigned(assigned, '0);
		end
	endtask

	// random values in the middle half keep every channel away from the extremes
	task automatic jitter(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			for (int j = 0; j < NUM_SOURCES; j++) begin
				spinner[j] <= 8'h40 + 8'($random(seed) & 32'h7f);
				stick[j].x <= 8'($random(seed) & 32'h7f) - 8'd64;
				stick[j].y <= 8'($random(seed) & 32'h7f) - 8'd64;
			end
			buttons_in <= 4'($random(seed));
			@(negedge clk);
			check_assigned(assigned, '0);
		end
	endtask

	// one report toggle, position visible one cycle after it is sampled
	task automatic mouse_step(input int delta);
		@(posedge clk);
		mouse.strobe <= ~mouse.strobe;
		mouse.dx_sign <= (delta < 0);
		mouse.dx <= 8'(delta);
		// model steps at the edge that samples the toggle
		@(posedge clk);
		exp_acc = clamp(exp_acc + clamp(delta, -MOUSE_STEP_MAX, MOUSE_STEP_MAX),
			MOUSE_POS_MIN, MOUSE_POS_MAX);
		@(negedge clk);
	endtask

	task automatic begin_test();
		test_err_start = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_err_start)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - test_err_start);
	endtask

	initial begin
		int waited;
		seed = 32'h25c9_6c34;
		// slot 1 stays disabled until the mouse test
		mask = 4'b1101;
		stick = '0;
		spinner = {NUM_SOURCES{8'h80}};
		mouse = '0;
		buttons_in = '0;
		exp_filled = '0;
		for (int s = 0; s < NUM_SLOTS; s++)
			exp_src[s] = '0;
		exp_acc = 0;
		check_en = 1'b0;
		errors = 0;
		tests = 0;

		waited = 0;
		while (reset !== 1'b0 && waited < 40) begin
			@(negedge clk);
			waited++;
		end
		if (reset !== 1'b0) begin
			errors++;
			$display("reset was never released");
		end

		begin_test();
		@(negedge clk);
		check_assigned(assigned, '0);
		check_en = 1'b1;
		jitter(20);
		finish_test("reset state and mid-range jitter");

		begin_test();
		check_en = 1'b0;
		@(posedge clk);
		spinner[2] <= 8'hf0;
		expect_claim(source_of(KIND_SPINNER, 2, 1'b0));
		jitter(8);
		@(posedge clk);
		spinner[2] <= 8'h08;
		expect_no_claim(6);
		finish_test("spinner 2 claims the lowest slot once");

		// slot 1 is disabled so the stick lands in slot 2
		begin_test();
		check_en = 1'b0;
		@(posedge clk);
		stick[1].y <= 8'sh75;
		expect_claim(source_of(KIND_STICK, 1, 1'b0));
		jitter(8);
		@(posedge clk);
		stick[1].x <= 8'h90;
		expect_no_claim(6);
		finish_test("stick 1 y axis claims the next enabled slot");

		// spinner 0 outranks stick 3 y in the same cycle
		begin_test();
		check_en = 1'b0;
		@(posedge clk);
		spinner[0] <= 8'h05;
		stick[3].y <= 8'sh7a;
		expect_claim(source_of(KIND_SPINNER, 0, 1'b0));
		expect_no_claim(4);
		jitter(6);
		finish_test("masked slot skipped and same cycle priority");

		begin_test();
		check_en = 1'b0;
		@(posedge clk);
		mask <= 4'b1111;
		mouse.button <= 1'b1;
		expect_claim(source_of(KIND_MOUSE, 0, 1'b0));
		jitter(4);
		@(posedge clk);
		mouse.button <= 1'b0;
		for (int i = 0; i < 10; i++)
			mouse_step(100);
		mouse_step(200);
		for (int i = 0; i < 20; i++)
			mouse_step(-100);
		mouse_step(-200);
		mouse_step(7);
		mouse_step(-3);
		finish_test("mouse press and clamped position");

		// every slot is now filled
		begin_test();
		@(posedge clk);
		stick[3].y <= 8'sh80;
		stick[0].x <= 8'sh7f;
		spinner[1] <= 8'hff;
		expect_no_claim(8);
		jitter(6);
		finish_test("no claim once all slots are filled");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset
// 100 ns clock, reset held high for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	end

endmodule
